/* Bender.yml */
package:
  name: flag_regfile

sources:
  - common/flag_rf_pkg.sv
  - bank/flag_bank.sv
  - bank/flag_bank_array.sv
  - verilog/flag_bypass.sv
  - verilog/flag_regfile.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_flag_regfile.sv

/* bank/flag_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One bank of 2^ROW_BITS flag entries, read during write gives new data.
// Allocate beats a staged write to the same row, the clear sweep beats both.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module flag_bank #(
  parameter int ROW_BITS = 4
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire [ROW_BITS-1:0]       row_wr_addr [flag_rf_pkg::NUM_WR],
  input  wire flag_rf_pkg::flag_t  row_wr_data [flag_rf_pkg::NUM_WR],
  input  wire                      row_wr_en   [flag_rf_pkg::NUM_WR],
  input  wire [ROW_BITS-1:0]       row_new_addr,
  input  wire                      row_new_en,
  input  wire [ROW_BITS-1:0]       clear_row,
  input  wire                      clear_en,
  input  wire [ROW_BITS-1:0]       row_read_addr,
  input  wire                      read_en,
  input  wire [ROW_BITS-1:0]       row_retire_addr,
  input  wire                      retire_en,
  output flag_rf_pkg::entry_t      read_entry,
  output flag_rf_pkg::flag_t       retire_flags
);

  localparam int ROWS = 2 ** ROW_BITS;

  flag_rf_pkg::entry_t mem [ROWS];

  logic [ROW_BITS-1:0] read_row_q;
  logic [ROW_BITS-1:0] retire_row_q;

  // Later assignments take priority within the same edge.
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < flag_rf_pkg::NUM_WR; i++)
    begin
      if (row_wr_en[i])
        mem[row_wr_addr[i]] <= {1'b0, row_wr_data[i]};
    end
    if (row_new_en)
      mem[row_new_addr] <= '1;
    if (clear_en)
      mem[clear_row] <= '0;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read_row_q   <= '0;
      retire_row_q <= '0;
    end
    else
    begin
      if (read_en)
        read_row_q <= row_read_addr;
      if (retire_en)
        retire_row_q <= row_retire_addr;
    end
  end

  assign read_entry   = mem[read_row_q];
  assign retire_flags = mem[retire_row_q][flag_rf_pkg::FLAG_W-1:0];

endmodule

`default_nettype wire

/* bank/flag_bank_array.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Low BANK_BITS of an address pick the bank, the rest pick the row.
// After reset one row per cycle is cleared in every bank; no external
// write, allocate or read may be issued while init_busy is high.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module flag_bank_array #(
  parameter int BANK_BITS = 2,
  parameter int ROW_BITS  = 4
) (
  input  wire                              clk,
  input  wire                              rst,
  input  wire [BANK_BITS+ROW_BITS-1:0]     stg_addr [flag_rf_pkg::NUM_WR],
  input  wire flag_rf_pkg::flag_t          stg_data [flag_rf_pkg::NUM_WR],
  input  wire                              stg_en   [flag_rf_pkg::NUM_WR],
  input  wire [BANK_BITS+ROW_BITS-1:0]     new_addr,
  input  wire                              new_en,
  input  wire [BANK_BITS+ROW_BITS-1:0]     read_addr,
  input  wire                              read_en,
  input  wire [BANK_BITS+ROW_BITS-1:0]     retire_addr,
  input  wire                              retire_en,
  output flag_rf_pkg::entry_t              bank_read_data,
  output flag_rf_pkg::flag_t               retire_data,
  output logic                             init_busy
);

  localparam int NUM_BANKS = 2 ** BANK_BITS;
  localparam int NUM_WR    = flag_rf_pkg::NUM_WR;

  logic [ROW_BITS-1:0] stg_row [NUM_WR];

  flag_rf_pkg::entry_t bank_read   [NUM_BANKS];
  flag_rf_pkg::flag_t  bank_retire [NUM_BANKS];

  logic [BANK_BITS-1:0] read_bank_q;
  logic [BANK_BITS-1:0] retire_bank_q;

  flag_rf_pkg::init_state_e init_state;
  logic [ROW_BITS-1:0]      clear_row;

  for (genvar i = 0; i < NUM_WR; i++)
  begin : g_stg_row
    assign stg_row[i] = stg_addr[i][BANK_BITS +: ROW_BITS];
  end

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    logic wr_hit [NUM_WR];
    logic new_hit;
    logic read_hit;
    logic retire_hit;

    for (genvar i = 0; i < NUM_WR; i++)
    begin : g_wr_hit
      assign wr_hit[i] = stg_en[i] && (stg_addr[i][BANK_BITS-1:0] == BANK_BITS'(b));
    end

    assign new_hit    = new_en && (new_addr[BANK_BITS-1:0] == BANK_BITS'(b));
    assign read_hit   = read_en && (read_addr[BANK_BITS-1:0] == BANK_BITS'(b));
    assign retire_hit = retire_en && (retire_addr[BANK_BITS-1:0] == BANK_BITS'(b));

    flag_bank #(
      .ROW_BITS (ROW_BITS)
    ) u_bank (
      .clk             (clk),
      .rst             (rst),
      .row_wr_addr     (stg_row),
      .row_wr_data     (stg_data),
      .row_wr_en       (wr_hit),
      .row_new_addr    (new_addr[BANK_BITS +: ROW_BITS]),
      .row_new_en      (new_hit),
      .clear_row       (clear_row),
      .clear_en        (init_busy),
      .row_read_addr   (read_addr[BANK_BITS +: ROW_BITS]),
      .read_en         (read_hit),
      .row_retire_addr (retire_addr[BANK_BITS +: ROW_BITS]),
      .retire_en       (retire_hit),
      .read_entry      (bank_read[b]),
      .retire_flags    (bank_retire[b])
    );
  end

  // Bank selects follow the row addresses held inside the banks.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read_bank_q   <= '0;
      retire_bank_q <= '0;
    end
    else
    begin
      if (read_en)
        read_bank_q <= read_addr[BANK_BITS-1:0];
      if (retire_en)
        retire_bank_q <= retire_addr[BANK_BITS-1:0];
    end
  end

  assign bank_read_data = bank_read[read_bank_q];
  assign retire_data    = bank_retire[retire_bank_q];

  // Clear sweep, row 0 in the first cycle after reset.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      init_state <= flag_rf_pkg::ST_CLEAR;
      clear_row  <= '0;
    end
    else
    begin
      case (init_state)
        flag_rf_pkg::ST_CLEAR:
        begin
          clear_row <= clear_row + 1'b1;
          if (clear_row == {ROW_BITS{1'b1}})
            init_state <= flag_rf_pkg::ST_RUN;
        end
        default:
        begin
          clear_row <= '0;
        end
      endcase
    end
  end

  assign init_busy = (init_state == flag_rf_pkg::ST_CLEAR);

endmodule

`default_nettype wire

/* common/flag_rf_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and types shared by the flag register file.
// An entry holds a pending bit above the six flag bits.
// A zero gazump vector means the read data came from a bank.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package flag_rf_pkg;

  localparam int FLAG_W = 6;
  localparam int NUM_WR = 3;

  // Flags of one physical register.
  typedef logic [FLAG_W-1:0] flag_t;

  // Pending bit in the top position.
  typedef logic [FLAG_W:0] entry_t;

  // Low half marks live ports, high half marks staged ports.
  typedef logic [2*NUM_WR-1:0] gazump_t;

  typedef enum logic {
    ST_CLEAR,
    ST_RUN
  } init_state_e;

endpackage

`default_nettype wire

/* flag_regfile.f */
common/flag_rf_pkg.sv
bank/flag_bank.sv
bank/flag_bank_array.sv
verilog/flag_bypass.sv
verilog/flag_regfile.sv
sim/tb_clock_gen.sv
sim/tb_flag_regfile.sv

/* sim/flag_rf_cases.txt */
# Columns: op then hex arguments. wr port addr data | new addr | rd addr | ret addr
# chkr entry gazump | chkt flags | step n | burst n | rdzero. step runs the cycle.
test read_after_init
rdzero
test write_then_read
wr 0 05 2a
step 1
step 2
rd 05
step 1
chkr 2a 00
step 1
test staged_forward
wr 1 09 15
rd 09
step 1
chkr 15 10
step 1
test live_beats_staged
wr 2 0c 11
rd 0c
step 1
wr 0 0c 07
chkr 07 01
step 1
step 2
rd 0c
step 1
chkr 07 00
step 1
test alloc_and_retire
new 20
step 1
rd 20
step 1
chkr 7f 00
step 1
ret 20
wr 0 20 0a
step 1
chkt 3f
step 1
rd 20
ret 20
step 1
chkr 0a 00
chkt 0a
step 1
test random_burst_a
burst 40
test random_burst_b
burst 40

/* sim/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running testbench clock with a synchronous reset pulse.
// rst drops on a rising edge after RST_CYCLES edges.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* sim/tb_flag_regfile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Runs sim/flag_rf_cases.txt from the project root against the register file.
// Inputs change on the rising edge, outputs are sampled on the falling edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module tb_flag_regfile;

  localparam int NWR     = flag_rf_pkg::NUM_WR;
  localparam int ADDR_W  = 6;
  localparam int ENTRIES = 64;

  logic clk;
  logic rst;

  logic [ADDR_W-1:0]    wr_addr [NWR];
  flag_rf_pkg::flag_t   wr_data [NWR];
  logic                 wr_en   [NWR];
  logic [ADDR_W-1:0]    new_addr;
  logic                 new_en;
  logic [ADDR_W-1:0]    read_addr;
  logic                 read_en;
  logic [ADDR_W-1:0]    retire_addr;
  logic                 retire_en;
  flag_rf_pkg::entry_t  read_data;
  flag_rf_pkg::gazump_t read_gazump;
  flag_rf_pkg::flag_t   retire_data;
  logic                 init_busy;

  // Operations collected for the next cycle.
  logic [ADDR_W-1:0] p_wr_addr [NWR];
  logic [5:0]        p_wr_data [NWR];
  logic              p_wr_en   [NWR];
  logic [ADDR_W-1:0] p_new_addr;
  logic              p_new_en;
  logic [ADDR_W-1:0] p_rd_addr;
  logic              p_rd_en;
  logic [ADDR_W-1:0] p_ret_addr;
  logic              p_ret_en;
  logic              p_chk_r;
  logic [6:0]        p_exp_r;
  logic [5:0]        p_exp_g;
  logic              p_chk_t;
  logic [5:0]        p_exp_t;

  // Reference model of the entries and of the write stage.
  logic [6:0]        m_mem [ENTRIES];
  logic [ADDR_W-1:0] m_stg_addr [NWR];
  logic [5:0]        m_stg_data [NWR];
  logic              m_stg_en   [NWR];
  logic [ADDR_W-1:0] m_rq;
  logic              m_rq_valid;
  logic [ADDR_W-1:0] m_tq;
  logic              m_tq_valid;

  int          errors;
  int          test_errs;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          cyc;
  int          limit;
  int unsigned lcg_state;
  logic [255:0] test_name;

  tb_clock_gen #(
    .PERIOD     (40),
    .RST_CYCLES (16)
  ) u_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  flag_regfile #(
    .BANK_BITS (2),
    .ROW_BITS  (4)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_en       (wr_en),
    .new_addr    (new_addr),
    .new_en      (new_en),
    .read_addr   (read_addr),
    .read_en     (read_en),
    .retire_addr (retire_addr),
    .retire_en   (retire_en),
    .read_data   (read_data),
    .read_gazump (read_gazump),
    .retire_data (retire_data),
    .init_busy   (init_busy)
  );

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (limit > 0 && cyc > limit)
    begin
      $display("Timeout: the run went past %0d cycles", limit);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] got_v);
    checks++;
    if (got_v !== exp_v)
    begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
      errors++;
      test_errs++;
    end
  endtask

  task automatic report_short_line(input int got, input int want);
    if (got != want)
    begin
      $display("A case file line is missing arguments, read %0d of %0d", got, want);
      errors++;
      test_errs++;
    end
  endtask

  task automatic close_test;
    if (test_name != 0)
    begin
      tests_run++;
      if (test_errs != 0)
        tests_failed++;
      $display("Test %0s: %0s (%0d errors)", test_name,
               (test_errs == 0) ? "ok" : "FAILED", test_errs);
    end
    test_errs = 0;
  endtask

  task automatic clear_pending;
    for (int i = 0; i < NWR; i++)
      p_wr_en[i] = 1'b0;
    p_new_en = 1'b0;
    p_rd_en  = 1'b0;
    p_ret_en = 1'b0;
    p_chk_r  = 1'b0;
    p_chk_t  = 1'b0;
  endtask

  // Live writes beat staged writes, staged writes beat the stored entry.
  task automatic predict_read(output logic [6:0] e, output logic [5:0] g);
    e = m_mem[m_rq];
    g = '0;
    for (int i = 0; i < NWR; i++)
    begin
      if (m_stg_en[i] && m_stg_addr[i] == m_rq)
      begin
        e = {1'b0, m_stg_data[i]};
        g = 6'(1) << (NWR + i);
      end
    end
    for (int i = 0; i < NWR; i++)
    begin
      if (p_wr_en[i] && p_wr_addr[i] == m_rq)
      begin
        e = {1'b0, p_wr_data[i]};
        g = 6'(1) << i;
      end
    end
  endtask

  task automatic advance_model;
    for (int i = 0; i < NWR; i++)
    begin
      if (m_stg_en[i])
        m_mem[m_stg_addr[i]] = {1'b0, m_stg_data[i]};
    end
    if (p_new_en)
      m_mem[p_new_addr] = 7'h7f;
    for (int i = 0; i < NWR; i++)
    begin
      m_stg_en[i]   = p_wr_en[i];
      m_stg_addr[i] = p_wr_addr[i];
      m_stg_data[i] = p_wr_data[i];
    end
    if (p_rd_en)
    begin
      m_rq       = p_rd_addr;
      m_rq_valid = 1'b1;
    end
    if (p_ret_en)
    begin
      m_tq       = p_ret_addr;
      m_tq_valid = 1'b1;
    end
  endtask

  task automatic run_cycle;
    logic [6:0] exp_e;
    logic [5:0] exp_g;
    @(posedge clk);
    for (int i = 0; i < NWR; i++)
    begin
      wr_en[i]   <= p_wr_en[i];
      wr_addr[i] <= p_wr_addr[i];
      wr_data[i] <= p_wr_data[i];
    end
    new_en      <= p_new_en;
    new_addr    <= p_new_addr;
    read_en     <= p_rd_en;
    read_addr   <= p_rd_addr;
    retire_en   <= p_ret_en;
    retire_addr <= p_ret_addr;
    @(negedge clk);
    if (m_rq_valid)
    begin
      predict_read(exp_e, exp_g);
      check_val("read_data", exp_e, read_data);
      check_val("read_gazump", exp_g, read_gazump);
    end
    if (m_tq_valid)
      check_val("retire_data", m_mem[m_tq][5:0], retire_data);
    if (p_chk_r)
    begin
      check_val("read_data", p_exp_r, read_data);
      check_val("read_gazump", p_exp_g, read_gazump);
    end
    if (p_chk_t)
      check_val("retire_data", p_exp_t, retire_data);
    advance_model;
    clear_pending;
  endtask

  // Four addresses a quarter apart never collide.
  task automatic random_burst(input int n);
    logic [ADDR_W-1:0] base;
    for (int c = 0; c < n; c++)
    begin
      lcg_state = lcg_next(lcg_state);
      base = lcg_state[21:16];
      for (int i = 0; i < NWR; i++)
      begin
        p_wr_en[i]   = lcg_state[24 + i];
        p_wr_addr[i] = base + ADDR_W'(17 * i);
        p_wr_data[i] = lcg_state[13:8] ^ 6'(i * 11);
      end
      p_new_en   = lcg_state[27] & lcg_state[28];
      p_new_addr = base + 6'd51;
      lcg_state  = lcg_next(lcg_state);
      p_rd_en    = lcg_state[20] | lcg_state[21];
      p_rd_addr  = lcg_state[22] ? base + ADDR_W'(17 * lcg_state[25:24]) : lcg_state[31:26];
      p_ret_en   = lcg_state[23];
      p_ret_addr = lcg_state[17:12];
      run_cycle;
    end
    run_cycle;
  endtask

  task automatic read_zero_sweep;
    for (int a = 0; a <= ENTRIES; a++)
    begin
      p_rd_en   = (a < ENTRIES);
      p_rd_addr = ADDR_W'(a);
      run_cycle;
      if (a > 0)
      begin
        check_val("read_data", 0, read_data);
        check_val("read_gazump", 0, read_gazump);
      end
    end
  endtask

  initial
  begin
    int fd;
    int n_lines;
    int busy_cycles;
    int r;
    int a1;
    int a2;
    int a3;
    logic [127:0]  op;
    logic [8*200-1:0] skip;
    errors = 0;
    test_errs = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    cyc = 0;
    limit = 0;
    lcg_state = 21752;
    test_name = 0;
    for (int i = 0; i < NWR; i++)
    begin
      wr_en[i]   = 1'b0;
      wr_addr[i] = '0;
      wr_data[i] = '0;
      p_wr_addr[i] = '0;
      p_wr_data[i] = '0;
      m_stg_en[i] = 1'b0;
      m_stg_addr[i] = '0;
      m_stg_data[i] = '0;
    end
    new_en = 1'b0;
    new_addr = '0;
    read_en = 1'b0;
    read_addr = '0;
    retire_en = 1'b0;
    retire_addr = '0;
    p_new_addr = '0;
    p_rd_addr = '0;
    p_ret_addr = '0;
    p_exp_r = '0;
    p_exp_g = '0;
    p_exp_t = '0;
    clear_pending;
    for (int i = 0; i < ENTRIES; i++)
      m_mem[i] = '0;
    m_rq = '0;
    m_tq = '0;
    m_rq_valid = 1'b0;
    m_tq_valid = 1'b0;

    fd = $fopen("sim/flag_rf_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the case file sim/flag_rf_cases.txt");
      $display("Verification failed");
      $finish;
    end
    else
    begin
      n_lines = 0;
      while ($fgets(skip, fd) != 0)
        n_lines++;
      $fclose(fd);
      limit = 16 + 16 + n_lines * 8 + 100;

      // Init sweep length.
      test_name = "init_sweep";
      @(negedge rst);
      busy_cycles = 0;
      @(negedge clk);
      while (init_busy === 1'b1)
      begin
        busy_cycles++;
        @(negedge clk);
      end
      check_val("init_busy cycles", 16, busy_cycles);

      fd = $fopen("sim/flag_rf_cases.txt", "r");
      while ($fscanf(fd, "%s", op) == 1)
      begin
        if (op == "#")
          r = $fgets(skip, fd);
        else if (op == "test")
        begin
          close_test;
          r = $fscanf(fd, "%s", test_name);
          report_short_line(r, 1);
        end
        else if (op == "wr")
        begin
          r = $fscanf(fd, "%h %h %h", a1, a2, a3);
          report_short_line(r, 3);
          p_wr_en[a1]   = 1'b1;
          p_wr_addr[a1] = a2[ADDR_W-1:0];
          p_wr_data[a1] = a3[5:0];
        end
        else if (op == "new")
        begin
          r = $fscanf(fd, "%h", a1);
          report_short_line(r, 1);
          p_new_en   = 1'b1;
          p_new_addr = a1[ADDR_W-1:0];
        end
        else if (op == "rd")
        begin
          r = $fscanf(fd, "%h", a1);
          report_short_line(r, 1);
          p_rd_en   = 1'b1;
          p_rd_addr = a1[ADDR_W-1:0];
        end
        else if (op == "ret")
        begin
          r = $fscanf(fd, "%h", a1);
          report_short_line(r, 1);
          p_ret_en   = 1'b1;
          p_ret_addr = a1[ADDR_W-1:0];
        end
        else if (op == "chkr")
        begin
          r = $fscanf(fd, "%h %h", a1, a2);
          report_short_line(r, 2);
          p_chk_r = 1'b1;
          p_exp_r = a1[6:0];
          p_exp_g = a2[5:0];
        end
        else if (op == "chkt")
        begin
          r = $fscanf(fd, "%h", a1);
          report_short_line(r, 1);
          p_chk_t = 1'b1;
          p_exp_t = a1[5:0];
        end
        else if (op == "step")
        begin
          r = $fscanf(fd, "%d", a1);
          report_short_line(r, 1);
          for (int k = 0; k < a1; k++)
            run_cycle;
        end
        else if (op == "rdzero")
          read_zero_sweep;
        else if (op == "burst")
        begin
          r = $fscanf(fd, "%d", a1);
          report_short_line(r, 1);
          random_burst(a1);
        end
        else
        begin
          $display("Unknown operation %0s in the case file", op);
          errors++;
          test_errs++;
        end
      end
      $fclose(fd);
      close_test;

      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
        $display("Verification passed");
      else
        $display("Verification failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog/flag_bypass.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write staging and read forwarding. Live writes beat staged writes,
// staged writes beat the bank. Allocates are never forwarded.
// Same-cycle writes to one address from two ports are undefined.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module flag_bypass #(
  parameter int BANK_BITS = 2,
  parameter int ROW_BITS  = 4
) (
  input  wire                              clk,
  input  wire                              rst,
  input  wire [BANK_BITS+ROW_BITS-1:0]     wr_addr [flag_rf_pkg::NUM_WR],
  input  wire flag_rf_pkg::flag_t          wr_data [flag_rf_pkg::NUM_WR],
  input  wire                              wr_en   [flag_rf_pkg::NUM_WR],
  input  wire [BANK_BITS+ROW_BITS-1:0]     read_addr,
  input  wire                              read_en,
  input  wire flag_rf_pkg::entry_t         bank_read_data,
  output logic [BANK_BITS+ROW_BITS-1:0]    stg_addr [flag_rf_pkg::NUM_WR],
  output flag_rf_pkg::flag_t               stg_data [flag_rf_pkg::NUM_WR],
  output logic                             stg_en   [flag_rf_pkg::NUM_WR],
  output flag_rf_pkg::entry_t              read_data,
  output flag_rf_pkg::gazump_t             read_gazump
);

  localparam int NUM_WR = flag_rf_pkg::NUM_WR;
  localparam int ADDR_W = BANK_BITS + ROW_BITS;

  logic [ADDR_W-1:0] read_addr_q;

  logic stg_hit  [NUM_WR];
  logic live_hit [NUM_WR];

  // Stage enables carry reset, stage payload does not.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_WR; i++)
        stg_en[i] <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < NUM_WR; i++)
        stg_en[i] <= wr_en[i];
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NUM_WR; i++)
    begin
      stg_addr[i] <= wr_addr[i];
      stg_data[i] <= wr_data[i];
    end
  end

  // Mirrors the row address held in the selected bank.
  always_ff @(posedge clk)
  begin
    if (rst)
      read_addr_q <= '0;
    else if (read_en)
      read_addr_q <= read_addr;
  end

  for (genvar i = 0; i < NUM_WR; i++)
  begin : g_match
    assign stg_hit[i]  = stg_en[i] && (stg_addr[i] == read_addr_q);
    assign live_hit[i] = wr_en[i] && (wr_addr[i] == read_addr_q);
  end

  // Staged sources are scanned first so a live match overrides them.
  always_comb
  begin
    read_data   = bank_read_data;
    read_gazump = '0;
    for (int i = NUM_WR - 1; i >= 0; i--)
    begin
      if (stg_hit[i])
      begin
        read_data   = {1'b0, stg_data[i]};
        read_gazump = '0;
        read_gazump[NUM_WR + i] = 1'b1;
      end
    end
    for (int i = NUM_WR - 1; i >= 0; i--)
    begin
      if (live_hit[i])
      begin
        read_data   = {1'b0, wr_data[i]};
        read_gazump = '0;
        read_gazump[i] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/flag_regfile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Banked flag register file, 2^(BANK_BITS+ROW_BITS) entries.
// Read data is valid the cycle after read_en; writes reach the banks
// two cycles after they are presented. Hold off traffic during init_busy.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

module flag_regfile #(
  parameter int BANK_BITS = 2,
  parameter int ROW_BITS  = 4
) (
  input  wire                              clk,
  input  wire                              rst,
  input  wire [BANK_BITS+ROW_BITS-1:0]     wr_addr [flag_rf_pkg::NUM_WR],
  input  wire flag_rf_pkg::flag_t          wr_data [flag_rf_pkg::NUM_WR],
  input  wire                              wr_en   [flag_rf_pkg::NUM_WR],
  input  wire [BANK_BITS+ROW_BITS-1:0]     new_addr,
  input  wire                              new_en,
  input  wire [BANK_BITS+ROW_BITS-1:0]     read_addr,
  input  wire                              read_en,
  input  wire [BANK_BITS+ROW_BITS-1:0]     retire_addr,
  input  wire                              retire_en,
  output flag_rf_pkg::entry_t              read_data,
  output flag_rf_pkg::gazump_t             read_gazump,
  output flag_rf_pkg::flag_t               retire_data,
  output logic                             init_busy
);

  localparam int NUM_WR = flag_rf_pkg::NUM_WR;
  localparam int ADDR_W = BANK_BITS + ROW_BITS;

  logic [ADDR_W-1:0]   stg_addr [NUM_WR];
  flag_rf_pkg::flag_t  stg_data [NUM_WR];
  logic                stg_en   [NUM_WR];
  flag_rf_pkg::entry_t bank_read_data;

  flag_bypass #(
    .BANK_BITS (BANK_BITS),
    .ROW_BITS  (ROW_BITS)
  ) u_bypass (
    .clk            (clk),
    .rst            (rst),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .wr_en          (wr_en),
    .read_addr      (read_addr),
    .read_en        (read_en),
    .bank_read_data (bank_read_data),
    .stg_addr       (stg_addr),
    .stg_data       (stg_data),
    .stg_en         (stg_en),
    .read_data      (read_data),
    .read_gazump    (read_gazump)
  );

  flag_bank_array #(
    .BANK_BITS (BANK_BITS),
    .ROW_BITS  (ROW_BITS)
  ) u_bank_array (
    .clk            (clk),
    .rst            (rst),
    .stg_addr       (stg_addr),
    .stg_data       (stg_data),
    .stg_en         (stg_en),
    .new_addr       (new_addr),
    .new_en         (new_en),
    .read_addr      (read_addr),
    .read_en        (read_en),
    .retire_addr    (retire_addr),
    .retire_en      (retire_en),
    .bank_read_data (bank_read_data),
    .retire_data    (retire_data),
    .init_busy      (init_busy)
  );

endmodule

`default_nettype wire
